// File: verilog/mipsParams.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define WORD_WIDTH 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// memories are addressed by word
`define MEM_ADDR_WIDTH 30

// first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// File: verilog/mipsPkg.sv
`include "mipsParams.svh"

package mipsPkg;

    typedef logic [`WORD_WIDTH-1:0] wordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regIndexT;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnAdd  = 6'h20,
        fnAddu = 6'h21,
        fnSub  = 6'h22,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpE;

    typedef enum logic [1:0] {
        fwdReg, // value read in decode
        fwdMem, // alu result of the memory stage
        fwdWb   // value being written back
    } fwdSelE;

    typedef struct packed {
        logic valid;
        aluOpE aluOp;
        logic useImmediate;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic destUsesRd; // r-type writes rd, the rest write rt
        regIndexT rs;
        regIndexT rt;
        regIndexT rd;
        logic [4:0] shamt;
        wordT rsValue;
        wordT rtValue;
        wordT immediate;
    } decodeToExecT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        regIndexT dest;
        wordT aluResult; // also the data address
        wordT storeData;
    } execToMemT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        regIndexT dest;
        wordT aluResult;
        wordT loadData;
    } memToWbT;

    function automatic wordT forwardValue(fwdSelE sel, wordT regValue, wordT memResult,
                                          wordT wbValue);
        case (sel)
            fwdMem: return memResult;
            fwdWb: return wbValue;
            default: return regValue;
        endcase
    endfunction

endpackage

// File: verilog/hazardIf.sv
interface hazardIf import mipsPkg::*; ();

    regIndexT idRs;
    regIndexT idRt;
    logic idUsesRs;
    logic idUsesRt;
    logic idIsBranch;

    logic exRegWrite;
    logic exMemRead;
    regIndexT exDest;
    regIndexT exRs;
    regIndexT exRt;

    logic memRegWrite;
    logic memMemRead;
    regIndexT memDest;
    logic memWaiting; // data access not yet acknowledged
    logic wbRegWrite;
    regIndexT wbDest;

    logic stallFrontEnd;
    logic bubbleExecute;
    logic freezeBackEnd;
    fwdSelE idRsFwd;
    fwdSelE idRtFwd;
    fwdSelE exRsFwd;
    fwdSelE exRtFwd;

    modport decode (
        output idRs, idRt, idUsesRs, idUsesRt, idIsBranch,
        input  stallFrontEnd, bubbleExecute, idRsFwd, idRtFwd
    );

    modport execute (
        output exRegWrite, exMemRead, exDest, exRs, exRt,
        input  freezeBackEnd, exRsFwd, exRtFwd
    );

    modport memory (
        output memRegWrite, memMemRead, memDest, memWaiting, wbRegWrite, wbDest
    );

    modport hazard (
        input  idRs, idRt, idUsesRs, idUsesRt, idIsBranch,
        input  exRegWrite, exMemRead, exDest, exRs, exRt,
        input  memRegWrite, memMemRead, memDest, memWaiting, wbRegWrite, wbDest,
        output stallFrontEnd, bubbleExecute, freezeBackEnd,
        output idRsFwd, idRtFwd, exRsFwd, exRtFwd
    );

endinterface

// File: verilog/registerFile.sv
`include "mipsParams.svh"

module registerFile import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  regIndexT readIndexA,
    input  regIndexT readIndexB,
    output wordT readDataA,
    output wordT readDataB,
    input  regIndexT writeIndex,
    input  wordT writeData,
    input  logic writeEnable
);

    wordT regs [`REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeIndex != '0) begin
            regs[writeIndex] <= writeData;
        end
    end

    // $zero reads as zero whatever was written
    assign readDataA = (readIndexA == '0) ? '0 : regs[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 : regs[readIndexB];

endmodule

// File: verilog/fetchStage.sv
`include "mipsParams.svh"

module fetchStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  logic redirect,
    input  wordT redirectTarget,
    output logic [`MEM_ADDR_WIDTH-1:0] instMemAddress,
    input  wordT instMemData,
    output wordT fetchedInstruction,
    output wordT fetchedPcPlus4
);

    wordT pc;
    wordT pcPlus4;

    assign pcPlus4 = pc + 32'd4;
    assign instMemAddress = pc[`WORD_WIDTH-1:2]; // word address

    // a redirect arrives while the delay slot is being fetched, so it only
    // changes the fetch after that slot
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
            fetchedInstruction <= '0; // all zero decodes as a no-op
        end else if (!stall) begin
            pc <= redirect ? redirectTarget : pcPlus4;
            fetchedInstruction <= instMemData;
            fetchedPcPlus4 <= pcPlus4;
        end
    end

endmodule

// File: verilog/decodeStage.sv
module decodeStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  wordT instruction,
    input  wordT pcPlus4,
    input  wordT memResult,
    input  wordT wbValue,
    input  regIndexT wbDest,
    input  logic wbRegWrite,
    hazardIf.decode hazard,
    output logic redirect,
    output wordT redirectTarget,
    output decodeToExecT toExec
);

    opcodeE opcode;
    functE funct;
    regIndexT rs;
    regIndexT rt;
    wordT rfDataA;
    wordT rfDataB;
    wordT rsValue;
    wordT rtValue;
    wordT immediate;
    wordT branchTarget;
    wordT jumpTarget;
    decodeToExecT next;
    logic signExtend;
    logic isBeq;
    logic isBne;
    logic isJump;
    logic operandsEqual;

    assign opcode = opcodeE'(instruction[31:26]);
    assign funct = functE'(instruction[5:0]);
    assign rs = instruction[25:21];
    assign rt = instruction[20:16];

    registerFile regs0 (
        .clock(clock),
        .reset(reset),
        .readIndexA(rs),
        .readIndexB(rt),
        .readDataA(rfDataA),
        .readDataB(rfDataB),
        .writeIndex(wbDest),
        .writeData(wbValue),
        .writeEnable(wbRegWrite)
    );

    assign rsValue = forwardValue(hazard.idRsFwd, rfDataA, memResult, wbValue);
    assign rtValue = forwardValue(hazard.idRtFwd, rfDataB, memResult, wbValue);
    assign immediate = signExtend ? {{16{instruction[15]}}, instruction[15:0]}
                                  : {16'h0000, instruction[15:0]};

    always_comb begin
        next = '0;
        next.valid = 1'b1;
        next.aluOp = aluAdd;
        next.rs = rs;
        next.rt = rt;
        next.rd = instruction[15:11];
        next.shamt = instruction[10:6];
        next.rsValue = rsValue;
        next.rtValue = rtValue;
        next.immediate = immediate;
        signExtend = 1'b1;
        isBeq = 1'b0;
        isBne = 1'b0;
        isJump = 1'b0;
        hazard.idUsesRs = 1'b0;
        hazard.idUsesRt = 1'b0;
        case (opcode)
            opSpecial: begin
                next.regWrite = 1'b1;
                next.destUsesRd = 1'b1;
                hazard.idUsesRs = 1'b1;
                hazard.idUsesRt = 1'b1;
                case (funct)
                    fnAdd, fnAddu: next.aluOp = aluAdd; // no overflow trap
                    fnSub, fnSubu: next.aluOp = aluSub;
                    fnAnd: next.aluOp = aluAnd;
                    fnOr: next.aluOp = aluOr;
                    fnXor: next.aluOp = aluXor;
                    fnNor: next.aluOp = aluNor;
                    fnSlt: next.aluOp = aluSlt;
                    fnSll: begin
                        next.aluOp = aluSll;
                        hazard.idUsesRs = 1'b0;
                    end
                    default: begin
                        next.regWrite = 1'b0; // unknown function runs as a no-op
                        hazard.idUsesRs = 1'b0;
                        hazard.idUsesRt = 1'b0;
                    end
                endcase
            end
            opAddi, opAddiu, opAndi, opOri, opLw: begin
                next.useImmediate = 1'b1;
                next.regWrite = 1'b1;
                next.memRead = (opcode == opLw);
                hazard.idUsesRs = 1'b1;
                if (opcode == opAndi) begin
                    next.aluOp = aluAnd;
                    signExtend = 1'b0;
                end else if (opcode == opOri) begin
                    next.aluOp = aluOr;
                    signExtend = 1'b0;
                end
            end
            opLui: begin
                next.aluOp = aluLui;
                next.useImmediate = 1'b1;
                next.regWrite = 1'b1;
                signExtend = 1'b0;
            end
            opSw: begin
                next.useImmediate = 1'b1;
                next.memWrite = 1'b1;
                hazard.idUsesRs = 1'b1;
                hazard.idUsesRt = 1'b1;
            end
            opBeq, opBne: begin
                isBeq = (opcode == opBeq);
                isBne = (opcode == opBne);
                hazard.idUsesRs = 1'b1;
                hazard.idUsesRt = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    assign hazard.idRs = rs;
    assign hazard.idRt = rt;
    assign hazard.idIsBranch = isBeq | isBne;

    // branches resolve here, the fetch stage ignores a redirect while stalled
    assign operandsEqual = (rsValue == rtValue);
    assign branchTarget = pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00}; // same 256MB region
    assign redirect = isJump | (isBeq & operandsEqual) | (isBne & ~operandsEqual);
    assign redirectTarget = isJump ? jumpTarget : branchTarget;

    always_ff @(posedge clock) begin
        if (reset || hazard.bubbleExecute) begin
            toExec.valid <= 1'b0;
        end else if (!hazard.stallFrontEnd) begin
            toExec <= next;
        end
    end

endmodule

// File: verilog/executeStage.sv
module executeStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  decodeToExecT fromDecode,
    input  wordT memResult,
    input  wordT wbValue,
    hazardIf.execute hazard,
    output execToMemT toMem
);

    wordT operandA;
    wordT rtForwarded;
    wordT operandB;
    wordT result;
    execToMemT next;

    assign operandA = forwardValue(hazard.exRsFwd, fromDecode.rsValue, memResult, wbValue);
    assign rtForwarded = forwardValue(hazard.exRtFwd, fromDecode.rtValue, memResult, wbValue);
    assign operandB = fromDecode.useImmediate ? fromDecode.immediate : rtForwarded;

    always_comb begin
        case (fromDecode.aluOp)
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOr: result = operandA | operandB;
            aluXor: result = operandA ^ operandB;
            aluNor: result = ~(operandA | operandB);
            aluSlt: result = wordT'($signed(operandA) < $signed(operandB));
            aluSll: result = operandB << fromDecode.shamt;
            aluLui: result = {operandB[15:0], 16'h0000};
            default: result = operandA + operandB; // add, also load/store address
        endcase
    end

    // a bubble keeps its stale fields, valid masks its side effects
    always_comb begin
        next.regWrite = fromDecode.valid & fromDecode.regWrite;
        next.memRead = fromDecode.valid & fromDecode.memRead;
        next.memWrite = fromDecode.valid & fromDecode.memWrite;
        next.dest = fromDecode.destUsesRd ? fromDecode.rd : fromDecode.rt;
        next.aluResult = result;
        next.storeData = rtForwarded;
    end

    assign hazard.exRegWrite = next.regWrite;
    assign hazard.exMemRead = next.memRead;
    assign hazard.exDest = next.dest;
    assign hazard.exRs = fromDecode.rs;
    assign hazard.exRt = fromDecode.rt;

    always_ff @(posedge clock) begin
        if (reset) begin
            toMem.regWrite <= 1'b0;
            toMem.memRead <= 1'b0;
            toMem.memWrite <= 1'b0;
        end else if (!hazard.freezeBackEnd) begin
            toMem <= next;
        end
    end

endmodule

// File: verilog/memoryStage.sv
`include "mipsParams.svh"

module memoryStage import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    input  execToMemT fromExec,
    output logic [`MEM_ADDR_WIDTH-1:0] dataMemAddress,
    output wordT dataMemWriteData,
    output logic dataMemRead,
    output logic dataMemWrite,
    input  wordT dataMemReadData,
    input  logic dataMemReady,
    hazardIf.memory hazard,
    output wordT memResult,
    output wordT wbValue,
    output regIndexT wbDest,
    output logic wbRegWrite
);

    memToWbT wbReg;

    // request stays up, with address and data, until ready is seen at an edge
    assign dataMemAddress = fromExec.aluResult[`WORD_WIDTH-1:2];
    assign dataMemWriteData = fromExec.storeData;
    assign dataMemRead = fromExec.memRead;
    assign dataMemWrite = fromExec.memWrite;
    assign hazard.memWaiting = (fromExec.memRead | fromExec.memWrite) & ~dataMemReady;

    assign memResult = fromExec.aluResult;
    assign hazard.memRegWrite = fromExec.regWrite;
    assign hazard.memMemRead = fromExec.memRead;
    assign hazard.memDest = fromExec.dest;

    always_ff @(posedge clock) begin
        if (reset) begin
            wbReg.regWrite <= 1'b0;
        end else if (!hazard.memWaiting) begin
            wbReg <= '{regWrite: fromExec.regWrite,
                       memToReg: fromExec.memRead,
                       dest: fromExec.dest,
                       aluResult: fromExec.aluResult,
                       loadData: dataMemReadData}; // read data valid with ready
        end
    end

    assign wbValue = wbReg.memToReg ? wbReg.loadData : wbReg.aluResult;
    assign wbDest = wbReg.dest;
    assign wbRegWrite = wbReg.regWrite;
    assign hazard.wbRegWrite = wbReg.regWrite;
    assign hazard.wbDest = wbReg.dest;

endmodule

// File: verilog/hazardUnit.sv
module hazardUnit import mipsPkg::*; (
    hazardIf.hazard hazard
);

    logic loadUse;
    logic branchOnExec;
    logic branchOnLoad;
    logic dependStall;

    // newest writer wins, a load in memory has no result to forward yet
    function automatic fwdSelE selectSource(regIndexT source);
        if (hazard.memRegWrite && !hazard.memMemRead && hazard.memDest != '0
                && hazard.memDest == source) begin
            return fwdMem;
        end
        if (hazard.wbRegWrite && hazard.wbDest != '0 && hazard.wbDest == source) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    // true when the instruction in decode reads a register that dest will write
    function automatic logic decodeReads(logic writes, regIndexT dest);
        return writes && dest != '0
            && ((hazard.idUsesRs && dest == hazard.idRs)
                || (hazard.idUsesRt && dest == hazard.idRt));
    endfunction

    assign hazard.idRsFwd = selectSource(hazard.idRs);
    assign hazard.idRtFwd = selectSource(hazard.idRt);
    assign hazard.exRsFwd = selectSource(hazard.exRs);
    assign hazard.exRtFwd = selectSource(hazard.exRt);

    assign loadUse = decodeReads(hazard.exMemRead, hazard.exDest);
    assign branchOnExec = hazard.idIsBranch & decodeReads(hazard.exRegWrite, hazard.exDest);
    assign branchOnLoad = hazard.idIsBranch & decodeReads(hazard.memMemRead, hazard.memDest);
    assign dependStall = loadUse | branchOnExec | branchOnLoad;

    // back-pressure holds everything, so no bubble is inserted then
    assign hazard.stallFrontEnd = dependStall | hazard.memWaiting;
    assign hazard.bubbleExecute = dependStall & ~hazard.memWaiting;
    assign hazard.freezeBackEnd = hazard.memWaiting;

endmodule

// File: verilog/mipsCore.sv
`include "mipsParams.svh"

module mipsCore import mipsPkg::*; (
    input  logic clock,
    input  logic reset,
    output logic [`MEM_ADDR_WIDTH-1:0] instMemAddress,
    input  wordT instMemData,
    output logic [`MEM_ADDR_WIDTH-1:0] dataMemAddress,
    output wordT dataMemWriteData,
    input  wordT dataMemReadData,
    output logic dataMemRead,
    output logic dataMemWrite,
    input  logic dataMemReady
);

    wordT fetchedInstruction;
    wordT fetchedPcPlus4;
    logic redirect;
    wordT redirectTarget;
    wordT memResult; // forwarded alu result of the memory stage
    wordT wbValue;
    regIndexT wbDest;
    logic wbRegWrite;
    decodeToExecT toExec;
    execToMemT toMem;

    hazardIf hazardBus ();

    fetchStage fetch0 (
        .clock(clock),
        .reset(reset),
        .stall(hazardBus.stallFrontEnd),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .instMemAddress(instMemAddress),
        .instMemData(instMemData),
        .fetchedInstruction(fetchedInstruction),
        .fetchedPcPlus4(fetchedPcPlus4)
    );

    decodeStage decode0 (
        .clock(clock),
        .reset(reset),
        .instruction(fetchedInstruction),
        .pcPlus4(fetchedPcPlus4),
        .memResult(memResult),
        .wbValue(wbValue),
        .wbDest(wbDest),
        .wbRegWrite(wbRegWrite),
        .hazard(hazardBus.decode),
        .redirect(redirect),
        .redirectTarget(redirectTarget),
        .toExec(toExec)
    );

    executeStage execute0 (
        .clock(clock),
        .reset(reset),
        .fromDecode(toExec),
        .memResult(memResult),
        .wbValue(wbValue),
        .hazard(hazardBus.execute),
        .toMem(toMem)
    );

    memoryStage memory0 (
        .clock(clock),
        .reset(reset),
        .fromExec(toMem),
        .dataMemAddress(dataMemAddress),
        .dataMemWriteData(dataMemWriteData),
        .dataMemRead(dataMemRead),
        .dataMemWrite(dataMemWrite),
        .dataMemReadData(dataMemReadData),
        .dataMemReady(dataMemReady),
        .hazard(hazardBus.memory),
        .memResult(memResult),
        .wbValue(wbValue),
        .wbDest(wbDest),
        .wbRegWrite(wbRegWrite)
    );

    hazardUnit hazard0 (
        .hazard(hazardBus.hazard)
    );

endmodule

// File: testbench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// every data word powers up with a value of its own
function automatic wordT dataFill(int index);
    return 32'hd00d_0000 | index;
endfunction

// runs instMem on an architectural model with one delay slot per branch
// and queues each store in program order and returns their count
function automatic int runReference(int maxSteps);
    wordT regs [32];
    wordT mem [dataWords];
    wordT pc;
    wordT npc;
    wordT nextNpc;
    wordT slot;
    wordT inst;
    wordT a;
    wordT b;
    wordT simm;
    wordT zimm;
    wordT address;
    wordT branchTarget;
    wordT jumpTarget;
    logic [5:0] op;
    logic [5:0] fn;
    int rt;
    int rd;
    int steps;
    logic halted;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < dataWords; i++) begin
        mem[i] = dataFill(i);
    end
    expAddress.delete();
    expData.delete();
    pc = `RESET_PC;
    npc = pc + 32'd4;
    steps = 0;
    halted = 1'b0;
    while (steps < maxSteps && !halted) begin
        inst = instMem[pc[7:2]];
        op = inst[31:26];
        fn = inst[5:0];
        rt = inst[20:16];
        rd = inst[15:11];
        a = regs[inst[25:21]];
        b = regs[rt];
        simm = {{16{inst[15]}}, inst[15:0]};
        zimm = {16'h0000, inst[15:0]};
        address = a + simm;
        slot = pc + 32'd4; // address of the delay slot
        branchTarget = slot + (simm << 2);
        jumpTarget = {slot[31:28], inst[25:0], 2'b00};
        nextNpc = npc + 32'd4;
        case (op)
            opSpecial: begin
                case (fn)
                    fnSll: regs[rd] = b << inst[10:6];
                    fnAdd, fnAddu: regs[rd] = a + b;
                    fnSub, fnSubu: regs[rd] = a - b;
                    fnAnd: regs[rd] = a & b;
                    fnOr: regs[rd] = a | b;
                    fnXor: regs[rd] = a ^ b;
                    fnNor: regs[rd] = ~(a | b);
                    fnSlt: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            opAddi, opAddiu: regs[rt] = a + simm; // both wrap since nothing traps
            opAndi: regs[rt] = a & zimm;
            opOri: regs[rt] = a | zimm;
            opLui: regs[rt] = {inst[15:0], 16'h0000};
            opLw: regs[rt] = mem[address[7:2]];
            opSw: begin
                mem[address[7:2]] = b;
                expAddress.push_back(address[31:2]);
                expData.push_back(b);
            end
            opBeq: if (a == b) nextNpc = branchTarget;
            opBne: if (a != b) nextNpc = branchTarget;
            opJ: begin
                nextNpc = jumpTarget;
                halted = (jumpTarget == pc); // final self loop
            end
            default: ;
        endcase
        regs[0] = '0;
        pc = npc;
        npc = nextNpc;
        steps++;
    end
    return expAddress.size();
endfunction

`endif

// File: testbench/tbMipsCore.sv
`include "mipsParams.svh"

module tbMipsCore import mipsPkg::*; ();

    localparam int instWords = 64;
    localparam int dataWords = 64; // both memories indexed by address bits [7:2]
    localparam int storeTimeout = 2000;

    logic clock;
    logic reset;
    logic [`MEM_ADDR_WIDTH-1:0] instMemAddress;
    wordT instMemData;
    logic [`MEM_ADDR_WIDTH-1:0] dataMemAddress;
    wordT dataMemWriteData;
    wordT dataMemReadData;
    logic dataMemRead;
    logic dataMemWrite;
    logic dataMemReady;

    wordT instMem [instWords];
    wordT dataMem [dataWords];
    logic [`MEM_ADDR_WIDTH-1:0] expAddress [$];
    wordT expData [$];
    int programSize;
    int expectedCount;
    int storeCount;
    int edgeCount;
    int waitCycles;
    integer seed;
    logic pending; // a data access has been seen and not yet answered
    int delayLeft;

    `include "refModel.svh"

    mipsCore dut0 (
        .clock(clock),
        .reset(reset),
        .instMemAddress(instMemAddress),
        .instMemData(instMemData),
        .dataMemAddress(dataMemAddress),
        .dataMemWriteData(dataMemWriteData),
        .dataMemReadData(dataMemReadData),
        .dataMemRead(dataMemRead),
        .dataMemWrite(dataMemWrite),
        .dataMemReady(dataMemReady)
    );

    assign instMemData = instMem[instMemAddress[5:0]];

    task automatic abortRun(string reason);
        $display("%0t: %s", $time, reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string what, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic wordT encodeR(functE fn, int rs, int rt, int rd, int shamt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    function automatic wordT encodeI(opcodeE op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic wordT encodeJ(int target);
        return {opJ, 26'(target)};
    endfunction

    task automatic emit(wordT inst);
        instMem[programSize] = inst;
        programSize++;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < instWords; i++) begin
            instMem[i] = '0; // sll $0 is a no-op
        end
        programSize = 0;
        emit(encodeI(opAddiu, 0, 1, 'h1234));
        emit(encodeI(opAddi, 0, 2, -13));
        emit(encodeR(fnAddu, 1, 2, 3, 0)); // back-to-back dependencies
        emit(encodeR(fnSubu, 3, 1, 4, 0));
        emit(encodeR(fnAnd, 4, 1, 5, 0));
        emit(encodeR(fnOr, 5, 2, 6, 0));
        emit(encodeR(fnXor, 6, 3, 7, 0));
        emit(encodeR(fnNor, 7, 4, 8, 0));
        emit(encodeR(fnSlt, 2, 1, 9, 0)); // -13 is below 0x1234 when signed
        emit(encodeR(fnSll, 0, 8, 10, 5));
        for (int i = 0; i < 8; i++) begin
            emit(encodeI(opSw, 0, 3 + i, 4 * i));
        end
        emit(encodeI(opAndi, 2, 11, 'h8f0f)); // zero-extended
        emit(encodeI(opOri, 1, 12, 'h8000));
        emit(encodeI(opLui, 0, 13, 'h8765));
        emit(encodeI(opAddiu, 13, 14, 'h8001)); // negative after sign extension
        for (int i = 0; i < 4; i++) begin
            emit(encodeI(opSw, 0, 11 + i, 32 + 4 * i));
        end
        emit(encodeI(opLw, 0, 15, 4));
        emit(encodeR(fnSub, 15, 1, 16, 0)); // load-use bubble
        emit(encodeI(opSw, 0, 16, 48));
        emit(encodeI(opLw, 0, 17, 48));
        emit(encodeI(opBne, 17, 16, 9)); // load feeds a branch that is not taken
        emit(encodeI(opAddiu, 0, 18, 7)); // delay slot
        emit(encodeI(opSw, 0, 18, 52));
        emit(encodeI(opLw, 0, 19, 200)); // loads the fill pattern of an untouched word
        emit(encodeI(opBeq, 19, 19, 3)); // taken to 38
        emit(encodeI(opSw, 0, 19, 56)); // delay slot
        emit(encodeI(opSw, 0, 1, 60)); // skipped
        emit(encodeI(opSw, 0, 2, 60)); // skipped
        emit(encodeR(fnAdd, 19, 18, 20, 0));
        emit(encodeI(opBne, 20, 0, 3)); // depends on execute and is taken to 43
        emit(encodeI(opSw, 0, 20, 64)); // delay slot
        emit(encodeI(opSw, 0, 3, 68)); // skipped
        emit(encodeI(opSw, 0, 4, 68)); // skipped
        emit(encodeI(opBeq, 20, 0, -8)); // not taken
        emit(encodeI(opSw, 0, 9, 72));
        emit(encodeJ(48));
        emit(encodeI(opSw, 0, 10, 76)); // delay slot of the jump
        emit(encodeI(opSw, 0, 5, 80)); // skipped
        emit(encodeI(opSw, 0, 14, 84));
        emit(encodeJ(49)); // parks here while the slot after it stays a no-op
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // data memory answers each request after 0 to 3 cycles
    initial begin
        seed = 32'he5a4;
        pending = 1'b0;
        delayLeft = 0;
        dataMemReady = 1'b0;
        dataMemReadData = '0;
        forever begin
            @(negedge clock);
            if (dataMemReady) begin
                dataMemReady = 1'b0; // access completed at the last rising edge
                pending = 1'b0;
            end
            if ((dataMemRead || dataMemWrite) && !pending) begin
                pending = 1'b1;
                delayLeft = $random(seed) & 3;
            end
            if (pending) begin
                if (delayLeft == 0) begin
                    dataMemReady = 1'b1;
                    dataMemReadData = dataMem[dataMemAddress[5:0]];
                end else begin
                    delayLeft--;
                end
            end
        end
    end

    // compares each completed store with the next expected one
    always @(posedge clock) begin
        edgeCount++;
        if (edgeCount >= 2 && edgeCount <= 6) begin // pc held until the first fetch
            checkValue("fetch address after reset", instMemAddress, `RESET_PC >> 2);
        end
        if (edgeCount >= 2 && edgeCount <= 8) begin // no instruction in memory yet
            checkValue("dataMemWrite before first access", dataMemWrite, 1'b0);
        end
        if (edgeCount >= 2 && storeCount == 0) begin // the program stores before any load
            checkValue("dataMemRead before first access", dataMemRead, 1'b0);
        end
        if (dataMemWrite === 1'b1 && dataMemReady === 1'b1) begin
            if (storeCount >= expectedCount) begin
                abortRun("a store arrived after the expected sequence was complete");
            end else begin
                checkValue("store address", dataMemAddress, expAddress[storeCount]);
                checkValue("store data", dataMemWriteData, expData[storeCount]);
                dataMem[dataMemAddress[5:0]] = dataMemWriteData;
                storeCount++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        storeCount = 0;
        edgeCount = 0;
        loadProgram();
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i] = dataFill(i);
        end
        expectedCount = runReference(1000);
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        waitCycles = 0;
        while (storeCount < expectedCount && waitCycles < storeTimeout) begin
            @(negedge clock);
            waitCycles++;
        end
        if (storeCount == expectedCount) begin
            repeat (20) @(negedge clock); // a duplicated store would still show up
            $display("RESULT: PASS");
            $finish;
        end else begin
            abortRun("timed out waiting for the expected stores");
        end
    end

endmodule

// File: vlog.f
+incdir+verilog
+incdir+testbench
verilog/mipsPkg.sv
verilog/hazardIf.sv
verilog/registerFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/mipsCore.sv
testbench/tbMipsCore.sv
